// File: source/trace_pkg.sv
// trace package for the commit monitor
// widths, CSR alias addresses and the observation event structs
package trace_pkg;

    localparam int OPID_W   = 7;   // 128 ops in flight
    localparam int XLEN     = 64;
    localparam int ST_TAG_W = 4;   // 16 store entries
    localparam int STRB_W   = 8;
    localparam int BYTES_W  = 4;

    typedef logic [OPID_W-1:0]   opid_t;
    typedef logic [XLEN-1:0]     xword_t;
    typedef logic [11:0]         csr_addr_t;
    typedef logic [ST_TAG_W-1:0] st_tag_t;
    typedef logic [STRB_W-1:0]   strb_t;
    typedef logic [BYTES_W-1:0]  byte_cnt_t;

    // supervisor aliases and user counters
    localparam csr_addr_t CSR_SSTATUS = 12'h100;
    localparam csr_addr_t CSR_SIE     = 12'h104;
    localparam csr_addr_t CSR_SIP     = 12'h144;
    localparam csr_addr_t CSR_CYCLE   = 12'hc00;
    localparam csr_addr_t CSR_INSTRET = 12'hc02;   // time sits in between

    localparam csr_addr_t SUPER_TO_MACHINE = 12'h200;
    localparam csr_addr_t USER_TO_MACHINE  = 12'h100;

    typedef struct packed {
        xword_t mstatus;
        xword_t mtvec;
        xword_t mepc;
        xword_t mcause;
    } csr_snap_t;

    typedef struct packed {
        logic      valid;
        opid_t     opid;
        csr_snap_t snap;   // CSRs seen at decode
    } decode_evt_t;

    typedef struct packed {
        logic        valid;
        opid_t       opid;
        xword_t      pc;
        logic [31:0] ir;
        logic        gpr;
        logic        csr;
        logic        mem;
        logic        exc;
        logic        eret;
        logic        rollback;   // cancels an exception commit
    } commit_evt_t;

    typedef struct packed {
        logic        valid;
        xword_t      pc;
        logic [31:0] ir;
        logic        gpr;
        logic        csr;
        logic        mem;
        logic        exc;
    } commit_rpt_t;

    typedef struct packed {
        logic      valid;
        csr_addr_t addr;
        xword_t    value;
    } csr_wr_t;

    typedef struct packed {
        logic    valid;
        st_tag_t tag;
        xword_t  addr;
        xword_t  wdata;
        strb_t   strobe;
    } st_req_t;

    typedef struct packed {
        logic    valid;
        logic    store;   // 0 for load
        st_tag_t tag;
        logic    miss;
    } st_resp_t;

    typedef struct packed {
        byte_cnt_t nbytes;   // 0 when nothing written
        xword_t    addr;
        xword_t    value;
    } mem_wr_t;

    typedef struct packed {
        logic be_valid;
        logic branch;
        logic jal;
        logic jalr;
        logic fe_redir;
    } mis_evt_t;

endpackage

// File: source/csr_snapshot_table.sv
// CSR snapshot table, one entry per operation id
`timescale 1ns/1ps

module csr_snapshot_table (
    input  logic                   clk,
    input  trace_pkg::decode_evt_t decode,
    input  trace_pkg::opid_t       rd_opid,
    output trace_pkg::csr_snap_t   rd_snap
);
    import trace_pkg::*;

    csr_snap_t snap_mem [2**OPID_W];   // indexed by opid

    // captured when the op leaves decode
    always_ff @(posedge clk) begin
        if (decode.valid) begin
            snap_mem[decode.opid] <= decode.snap;
        end
    end

    // async read, an entry written at one edge is seen by the next commit
    assign rd_snap = snap_mem[rd_opid];

endmodule

// File: source/commit_ctrl.sv
// commit control: filters commits into reports with their decode-time CSRs
// and remaps aliased CSR write addresses to machine addresses
`timescale 1ns/1ps

module commit_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  trace_pkg::commit_evt_t commit,
    input  trace_pkg::csr_wr_t     csr_in,
    output trace_pkg::opid_t       snap_rd_opid,
    input  trace_pkg::csr_snap_t   snap_rd,
    output trace_pkg::commit_rpt_t report,
    output trace_pkg::csr_snap_t   report_snap,
    output trace_pkg::csr_wr_t     csr_out
);
    import trace_pkg::*;

    logic      exc_cmt;    // exception or exception return
    logic      rpt_en;
    logic      super_alias;
    logic      user_cnt;
    csr_addr_t csr_addr;   // normalized write address

    // table lookup is combinational, so the snapshot lines up with the commit
    assign snap_rd_opid = commit.opid;

    assign exc_cmt = commit.exc | commit.eret;

    // a rolled back trap never shows up in the trace
    assign rpt_en = commit.valid & ~(exc_cmt & commit.rollback);

    assign super_alias = (csr_in.addr == CSR_SSTATUS) ||
                         (csr_in.addr == CSR_SIE) ||
                         (csr_in.addr == CSR_SIP);

    assign user_cnt = (csr_in.addr >= CSR_CYCLE) && (csr_in.addr <= CSR_INSTRET);

    always_comb begin
        csr_addr = csr_in.addr;
        if (super_alias) begin
            csr_addr = csr_in.addr + SUPER_TO_MACHINE;   // sstatus, sie, sip
        end else if (user_cnt) begin
            csr_addr = csr_in.addr - USER_TO_MACHINE;    // cycle, time, instret
        end
    end

    always_ff @(posedge clk) begin
        report.pc    <= commit.pc;
        report.ir    <= commit.ir;
        report.gpr   <= commit.gpr & ~exc_cmt;   // trap writes no register
        report.csr   <= commit.csr;
        report.mem   <= commit.mem & ~exc_cmt;   // nor memory
        report.exc   <= exc_cmt;
        report_snap  <= snap_rd;
        csr_out.addr  <= csr_addr;
        csr_out.value <= csr_in.value;
        if (rst) begin
            report.valid  <= 1'b0;
            csr_out.valid <= 1'b0;
        end else begin
            report.valid  <= rpt_en;
            csr_out.valid <= csr_in.valid;
        end
    end

endmodule

// File: source/store_track.sv
// store tracker: remembers store requests by tag and
// emits the memory write trace when a store hits in the data cache
`timescale 1ns/1ps

module store_track (
    input  logic                clk,
    input  logic                rst,
    input  trace_pkg::st_req_t  req,
    input  trace_pkg::st_resp_t resp,
    output trace_pkg::mem_wr_t  mem_wr,
    output logic                store_hit
);
    import trace_pkg::*;

    xword_t    st_addr [2**ST_TAG_W];
    xword_t    st_data [2**ST_TAG_W];   // already aligned to byte 0
    byte_cnt_t st_size [2**ST_TAG_W];

    logic [$clog2(STRB_W)-1:0] lo_idx;  // lowest enabled byte lane
    byte_cnt_t                 pop;

    // scan from the top so the lowest set lane wins
    always_comb begin
        lo_idx = '0;
        for (int i = STRB_W - 1; i >= 0; i--) begin
            if (req.strobe[i]) begin
                lo_idx = i[$clog2(STRB_W)-1:0];
            end
        end
    end

    assign pop = byte_cnt_t'($countones(req.strobe));

    always_ff @(posedge clk) begin
        if (req.valid) begin
            st_addr[req.tag] <= req.addr;
            st_data[req.tag] <= req.wdata >> {lo_idx, 3'b000};   // lane * 8 bits
            st_size[req.tag] <= pop;
        end
    end

    assign store_hit = resp.valid & resp.store & ~resp.miss;

    always_ff @(posedge clk) begin
        mem_wr.addr  <= st_addr[resp.tag];
        mem_wr.value <= st_data[resp.tag];
        if (rst) begin
            mem_wr.nbytes <= '0;
        end else begin
            mem_wr.nbytes <= store_hit ? st_size[resp.tag] : '0;   // 0 marks no write
        end
    end

endmodule

// File: source/perf_counters.sv
// performance counters for mispredictions, loads, stores and dcache misses
`timescale 1ns/1ps

module perf_counters (
    input  logic                clk,
    input  logic                rst,
    input  trace_pkg::mis_evt_t mis,
    input  trace_pkg::st_resp_t resp,
    input  logic                store_hit,
    output trace_pkg::xword_t   bmisp,
    output trace_pkg::xword_t   brmisp,
    output trace_pkg::xword_t   jmisp,
    output trace_pkg::xword_t   jrmisp,
    output trace_pkg::xword_t   fmisp,
    output trace_pkg::xword_t   loads,
    output trace_pkg::xword_t   stores,
    output trace_pkg::xword_t   dcmiss
);
    import trace_pkg::*;

    logic [7:0] evt;       // one increment strobe per counter
    logic       st_miss;
    xword_t     cnt [8];

    assign st_miss = resp.valid & resp.store & resp.miss;

    assign evt[0] = mis.be_valid;                   // any back-end mispredict
    assign evt[1] = mis.be_valid & mis.branch;
    assign evt[2] = mis.be_valid & mis.jal;
    assign evt[3] = mis.be_valid & mis.jalr;
    assign evt[4] = mis.fe_redir & ~mis.be_valid;   // back end takes priority
    assign evt[5] = resp.valid & ~resp.store;
    assign evt[6] = store_hit | st_miss;            // hits decided by store_track
    assign evt[7] = resp.valid & resp.miss;         // loads and stores alike

    always_ff @(posedge clk) begin
        for (int i = 0; i < $bits(evt); i++) begin
            if (rst) begin
                cnt[i] <= '0;
            end else if (evt[i]) begin
                cnt[i] <= cnt[i] + XLEN'(1);
            end
        end
    end

    assign bmisp  = cnt[0];
    assign brmisp = cnt[1];
    assign jmisp  = cnt[2];
    assign jrmisp = cnt[3];
    assign fmisp  = cnt[4];
    assign loads  = cnt[5];
    assign stores = cnt[6];
    assign dcmiss = cnt[7];

endmodule

// File: source/commit_monitor.sv
// commit monitor top
// ties the snapshot table, commit control, store tracker and counters together
`timescale 1ns/1ps

module commit_monitor (
    input  logic                   clk,
    input  logic                   rst,
    // observation strobes from the core
    input  trace_pkg::decode_evt_t decode,
    input  trace_pkg::commit_evt_t commit,
    input  trace_pkg::csr_wr_t     csr_in,
    input  trace_pkg::st_req_t     st_req,
    input  trace_pkg::st_resp_t    st_resp,
    input  trace_pkg::mis_evt_t    mis,
    // trace outputs
    output trace_pkg::commit_rpt_t report,
    output trace_pkg::csr_snap_t   report_snap,
    output trace_pkg::csr_wr_t     csr_out,
    output trace_pkg::mem_wr_t     mem_wr,
    // statistics
    output trace_pkg::xword_t      bmisp,
    output trace_pkg::xword_t      brmisp,
    output trace_pkg::xword_t      jmisp,
    output trace_pkg::xword_t      jrmisp,
    output trace_pkg::xword_t      fmisp,
    output trace_pkg::xword_t      loads,
    output trace_pkg::xword_t      stores,
    output trace_pkg::xword_t      dcmiss
);
    import trace_pkg::*;

    opid_t     snap_rd_opid;   // opid of the committing op
    csr_snap_t snap_rd;
    logic      store_hit;      // store response that hit the cache

    csr_snapshot_table u_snap_table (
        .clk     (clk),
        .decode  (decode),
        .rd_opid (snap_rd_opid),
        .rd_snap (snap_rd)
    );

    commit_ctrl u_commit_ctrl (
        .clk          (clk),
        .rst          (rst),
        .commit       (commit),
        .csr_in       (csr_in),
        .snap_rd_opid (snap_rd_opid),
        .snap_rd      (snap_rd),
        .report       (report),
        .report_snap  (report_snap),
        .csr_out      (csr_out)
    );

    store_track u_store_track (
        .clk       (clk),
        .rst       (rst),
        .req       (st_req),
        .resp      (st_resp),
        .mem_wr    (mem_wr),
        .store_hit (store_hit)
    );

    perf_counters u_perf_counters (
        .clk       (clk),
        .rst       (rst),
        .mis       (mis),
        .resp      (st_resp),
        .store_hit (store_hit),
        .bmisp     (bmisp),
        .brmisp    (brmisp),
        .jmisp     (jmisp),
        .jrmisp    (jrmisp),
        .fmisp     (fmisp),
        .loads     (loads),
        .stores    (stores),
        .dcmiss    (dcmiss)
    );

endmodule

// File: tests/commit_monitor_asserts.sv
// commit monitor checker, bound into the top level
// shadow state built from the input ports, compared by concurrent assertions
`timescale 1ns/1ps

module commit_monitor_asserts (
    input logic                   clk,
    input logic                   rst,
    input trace_pkg::commit_evt_t commit,
    input trace_pkg::csr_wr_t     csr_in,
    input trace_pkg::st_req_t     st_req,
    input trace_pkg::st_resp_t    st_resp,
    input trace_pkg::mis_evt_t    mis,
    input trace_pkg::commit_rpt_t report,
    input trace_pkg::csr_snap_t   report_snap,
    input trace_pkg::csr_wr_t     csr_out,
    input trace_pkg::mem_wr_t     mem_wr,
    input trace_pkg::xword_t      bmisp,
    input trace_pkg::xword_t      brmisp,
    input trace_pkg::xword_t      jmisp,
    input trace_pkg::xword_t      jrmisp,
    input trace_pkg::xword_t      fmisp,
    input trace_pkg::xword_t      loads,
    input trace_pkg::xword_t      stores,
    input trace_pkg::xword_t      dcmiss
);
    import trace_pkg::*;

    int unsigned fail_cnt = 0;   // watched by the testbench

    commit_evt_t last_cmt;
    csr_wr_t     last_csr;
    logic        trap;
    logic        exp_rpt;
    xword_t      tag_addr [2**ST_TAG_W];
    xword_t      tag_data [2**ST_TAG_W];
    strb_t       tag_strb [2**ST_TAG_W];
    mem_wr_t     exp_mem;
    logic [7:0]  inc;            // shadow counter increments
    xword_t      shadow [8];
    xword_t      actual [8];

    // same per-field pattern the stimulus uses at decode
    function automatic csr_snap_t expected_snap(input opid_t id);
        csr_snap_t s;
        s.mstatus = 64'h0000_000a_0000_1800 ^ xword_t'(id);
        s.mtvec   = 64'h0000_0000_8000_0100 ^ xword_t'(id);
        s.mepc    = 64'h0000_0000_8000_4000 ^ xword_t'(id);
        s.mcause  = 64'h8000_0000_0000_0007 ^ xword_t'(id);
        return s;
    endfunction

    function automatic csr_addr_t machine_addr(input csr_addr_t a);
        if (a == CSR_SSTATUS || a == CSR_SIE || a == CSR_SIP) begin
            return a + 12'h200;
        end
        if (a == CSR_CYCLE || a == CSR_CYCLE + 12'h1 || a == CSR_INSTRET) begin
            return a - 12'h100;   // time is cycle + 1
        end
        return a;
    endfunction

    function automatic byte_cnt_t byte_count(input strb_t strb);
        byte_cnt_t n;
        n = '0;
        for (int i = 0; i < STRB_W; i++) begin
            n = n + byte_cnt_t'(strb[i]);
        end
        return n;
    endfunction

    function automatic xword_t aligned(input xword_t data, input strb_t strb);
        for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
                return data >> (8 * i);
            end
        end
        return data;
    endfunction

    function automatic string cnt_name(input int i);
        case (i)
            0: return "bmisp";
            1: return "brmisp";
            2: return "jmisp";
            3: return "jrmisp";
            4: return "fmisp";
            5: return "loads";
            6: return "stores";
            default: return "dcmiss";
        endcase
    endfunction

    assign trap    = last_cmt.exc | last_cmt.eret;
    assign exp_rpt = last_cmt.valid & ~(trap & last_cmt.rollback);

    assign inc[0] = mis.be_valid;
    assign inc[1] = mis.be_valid & mis.branch;
    assign inc[2] = mis.be_valid & mis.jal;
    assign inc[3] = mis.be_valid & mis.jalr;
    assign inc[4] = mis.fe_redir & ~mis.be_valid;
    assign inc[5] = st_resp.valid & ~st_resp.store;
    assign inc[6] = st_resp.valid & st_resp.store;
    assign inc[7] = st_resp.valid & st_resp.miss;

    assign actual = '{bmisp, brmisp, jmisp, jrmisp, fmisp, loads, stores, dcmiss};

    always_ff @(posedge clk) begin
        last_cmt <= commit;
        last_csr <= csr_in;
        if (rst) begin
            last_cmt.valid <= 1'b0;   // events in reset leave no trace
            last_csr.valid <= 1'b0;
        end
        if (st_req.valid) begin
            tag_addr[st_req.tag] <= st_req.addr;
            tag_data[st_req.tag] <= st_req.wdata;
            tag_strb[st_req.tag] <= st_req.strobe;
        end
        exp_mem.addr  <= tag_addr[st_resp.tag];
        exp_mem.value <= aligned(tag_data[st_resp.tag], tag_strb[st_resp.tag]);
        if (rst || !(st_resp.valid && st_resp.store && !st_resp.miss)) begin
            exp_mem.nbytes <= '0;
        end else begin
            exp_mem.nbytes <= byte_count(tag_strb[st_resp.tag]);
        end
        for (int i = 0; i < 8; i++) begin
            if (rst) begin
                shadow[i] <= '0;
            end else if (inc[i]) begin
                shadow[i] <= shadow[i] + 64'd1;
            end
        end
    end

    a_reset_clear: assert property (@(posedge clk)
        $fell(rst) |-> !report.valid && !csr_out.valid && mem_wr.nbytes == '0)
        else begin
            fail_cnt++;
            $error("ERROR %0t report.valid csr_out.valid mem_wr.nbytes expected 0 0 0 got %b %b %0d",
                   $time, $sampled(report.valid), $sampled(csr_out.valid),
                   $sampled(mem_wr.nbytes));
        end

    a_rpt_valid: assert property (@(posedge clk) disable iff (rst) report.valid == exp_rpt)
        else begin
            fail_cnt++;
            $error("ERROR %0t report.valid expected %b got %b",
                   $time, $sampled(exp_rpt), $sampled(report.valid));
        end

    a_rpt_pc_ir: assert property (@(posedge clk) disable iff (rst)
        exp_rpt |-> report.pc == last_cmt.pc && report.ir == last_cmt.ir)
        else begin
            fail_cnt++;
            $error("ERROR %0t report.pc/ir expected %h/%h got %h/%h", $time,
                   $sampled(last_cmt.pc), $sampled(last_cmt.ir),
                   $sampled(report.pc), $sampled(report.ir));
        end

    // a trap reports with no register or memory effect
    a_rpt_flags: assert property (@(posedge clk) disable iff (rst)
        exp_rpt |-> {report.gpr, report.csr, report.mem, report.exc} ==
                    {last_cmt.gpr & ~trap, last_cmt.csr, last_cmt.mem & ~trap, trap})
        else begin
            fail_cnt++;
            $error("ERROR %0t report gpr/csr/mem/exc expected %b got %b", $time,
                   $sampled({last_cmt.gpr & ~trap, last_cmt.csr, last_cmt.mem & ~trap, trap}),
                   $sampled({report.gpr, report.csr, report.mem, report.exc}));
        end

    a_rpt_snap: assert property (@(posedge clk) disable iff (rst)
        last_cmt.valid |-> report_snap == expected_snap(last_cmt.opid))
        else begin
            fail_cnt++;
            $error("ERROR %0t report_snap expected %h got %h", $time,
                   expected_snap($sampled(last_cmt.opid)), $sampled(report_snap));
        end

    a_csr_valid: assert property (@(posedge clk) disable iff (rst)
        csr_out.valid == last_csr.valid)
        else begin
            fail_cnt++;
            $error("ERROR %0t csr_out.valid expected %b got %b",
                   $time, $sampled(last_csr.valid), $sampled(csr_out.valid));
        end

    a_csr_write: assert property (@(posedge clk) disable iff (rst)
        last_csr.valid |-> csr_out.addr == machine_addr(last_csr.addr) &&
                           csr_out.value == last_csr.value)
        else begin
            fail_cnt++;
            $error("ERROR %0t csr_out addr/value expected %h/%h got %h/%h", $time,
                   machine_addr($sampled(last_csr.addr)), $sampled(last_csr.value),
                   $sampled(csr_out.addr), $sampled(csr_out.value));
        end

    a_mem_bytes: assert property (@(posedge clk) disable iff (rst)
        mem_wr.nbytes == exp_mem.nbytes)
        else begin
            fail_cnt++;
            $error("ERROR %0t mem_wr.nbytes expected %0d got %0d",
                   $time, $sampled(exp_mem.nbytes), $sampled(mem_wr.nbytes));
        end

    a_mem_write: assert property (@(posedge clk) disable iff (rst)
        exp_mem.nbytes != '0 |-> mem_wr.addr == exp_mem.addr && mem_wr.value == exp_mem.value)
        else begin
            fail_cnt++;
            $error("ERROR %0t mem_wr addr/value expected %h/%h got %h/%h", $time,
                   $sampled(exp_mem.addr), $sampled(exp_mem.value),
                   $sampled(mem_wr.addr), $sampled(mem_wr.value));
        end

    for (genvar i = 0; i < 8; i++) begin : g_cnt
        a_counter: assert property (@(posedge clk) disable iff (rst) actual[i] == shadow[i])
            else begin
                fail_cnt++;
                $error("ERROR %0t %s expected %0d got %0d", $time, cnt_name(i),
                       $sampled(shadow[i]), $sampled(actual[i]));
            end
    end

endmodule

// File: tests/tb_commit_monitor.sv
// testbench for the commit monitor
// random event stimulus on falling edges, checks live in the bound checker
`timescale 1ns/1ps

module tb_commit_monitor;
    import trace_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int N_RAND     = 500;   // mixed random cycles
    localparam int RUN_CYCLES = 4 + 2**OPID_W + N_RAND + 4;
    localparam int TIMEOUT    = (RUN_CYCLES + 50) * CLK_PERIOD;

    logic        clk;
    logic        rst;
    decode_evt_t decode;
    commit_evt_t commit;
    csr_wr_t     csr_in;
    st_req_t     st_req;
    st_resp_t    st_resp;
    mis_evt_t    mis;
    commit_rpt_t report;
    csr_snap_t   report_snap;
    csr_wr_t     csr_out;
    mem_wr_t     mem_wr;
    xword_t      bmisp;
    xword_t      brmisp;
    xword_t      jmisp;
    xword_t      jrmisp;
    xword_t      fmisp;
    xword_t      loads;
    xword_t      stores;
    xword_t      dcmiss;
    integer      seed;

    commit_monitor UUT (.*);

    bind commit_monitor commit_monitor_asserts u_asserts (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    // each CSR is a fixed pattern XORed with the opid
    function automatic csr_snap_t make_snap(input opid_t id);
        csr_snap_t s;
        s.mstatus = 64'h0000_000a_0000_1800 ^ xword_t'(id);
        s.mtvec   = 64'h0000_0000_8000_0100 ^ xword_t'(id);
        s.mepc    = 64'h0000_0000_8000_4000 ^ xword_t'(id);
        s.mcause  = 64'h8000_0000_0000_0007 ^ xword_t'(id);
        return s;
    endfunction

    function automatic csr_addr_t pick_csr_addr(input logic [3:0] sel);
        case (sel)
            4'd0: return CSR_SSTATUS;
            4'd1: return CSR_SIE;
            4'd2: return CSR_SIP;
            4'd3: return CSR_CYCLE;
            4'd4: return CSR_CYCLE + 12'h1;   // time
            4'd5: return CSR_INSTRET;
            default: return csr_addr_t'(next_random());
        endcase
    endfunction

    function automatic strb_t random_strobe();
        strb_t s;
        s = strb_t'(next_random());
        if (s == '0) begin
            s = 8'h80;   // never an empty store
        end
        return s;
    endfunction

    task automatic clear_inputs();
        decode  = '0;
        commit  = '0;
        csr_in  = '0;
        st_req  = '0;
        st_resp = '0;
        mis     = '0;
    endtask

    task automatic random_cycle();
        logic [31:0] r;
        opid_t       id;
        r  = next_random();
        id = opid_t'(next_random());
        clear_inputs();
        decode.valid    = r[0];   // redecode keeps the same snapshot
        decode.opid     = id;
        decode.snap     = make_snap(id);
        commit.valid    = r[1];
        commit.opid     = opid_t'(next_random());
        commit.pc       = {next_random(), next_random()};
        commit.ir       = next_random();
        commit.gpr      = r[2];
        commit.csr      = r[3];
        commit.mem      = r[4];
        commit.exc      = (r[7:5] == 3'd0);
        commit.eret     = (r[7:5] == 3'd1);
        commit.rollback = r[8];
        csr_in.valid    = r[9];
        csr_in.addr     = pick_csr_addr(r[13:10]);
        csr_in.value    = {next_random(), next_random()};
        st_req.valid    = r[14];
        st_req.tag      = st_tag_t'(next_random());
        st_req.addr     = {next_random(), next_random()};
        st_req.wdata    = {next_random(), next_random()};
        st_req.strobe   = random_strobe();
        st_resp.valid   = r[15];
        st_resp.store   = r[16];
        st_resp.tag     = st_tag_t'(next_random());
        st_resp.miss    = r[17] & r[18];
        mis.be_valid    = r[19];
        mis.branch      = r[20];
        mis.jal         = r[21];
        mis.jalr        = r[22];
        mis.fe_redir    = r[23];
    endtask

    always @(negedge clk) begin
        if (UUT.u_asserts.fail_cnt != 0) begin
            stop_on_failure("an assertion in the bound checker failed");
        end
    end

    initial begin
        #(TIMEOUT);
        stop_on_failure("watchdog expired before the test sequence finished");
    end

    initial begin
        seed = 32'hc3fc;
        rst  = 1'b1;
        clear_inputs();
        // a busy core during reset must leave outputs and counters at zero
        repeat (3) begin
            @(negedge clk);
            random_cycle();
        end
        @(negedge clk);
        rst = 1'b0;
        // every opid and every store tag gets an entry before use
        for (int i = 0; i < 2**OPID_W; i++) begin
            clear_inputs();
            decode.valid = 1'b1;
            decode.opid  = opid_t'(i);
            decode.snap  = make_snap(opid_t'(i));
            if (i < 2**ST_TAG_W) begin
                st_req.valid  = 1'b1;
                st_req.tag    = st_tag_t'(i);
                st_req.addr   = {next_random(), next_random()};
                st_req.wdata  = {next_random(), next_random()};
                st_req.strobe = random_strobe();
            end
            @(negedge clk);
        end
        repeat (N_RAND) begin
            random_cycle();
            @(negedge clk);
        end
        clear_inputs();
        repeat (3) @(negedge clk);
        if (UUT.u_asserts.fail_cnt == 0) begin
            $display("test passed");
            $finish;
        end else begin
            stop_on_failure("checks failed during the run");
        end
    end

endmodule

// File: files.f
source/trace_pkg.sv
source/csr_snapshot_table.sv
source/commit_ctrl.sv
source/store_track.sv
source/perf_counters.sv
source/commit_monitor.sv
tests/commit_monitor_asserts.sv
tests/tb_commit_monitor.sv

// File: run.sh
#!/bin/sh
# compile and run the commit monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f files.f --top-module tb_commit_monitor

out=$(./obj_dir/Vtb_commit_monitor 2>&1) || true
echo "$out"
echo "$out" | grep -qx "test passed"
